//--- Makefile
TOOL      := verilator
FLAGS     := --binary --assert
TOP       := arbiter_tb
FILELIST  := noc_arbiter.f
BUILD_DIR := obj_dir
SIM_ARGS  := +verilator+error+limit+1000
LOG       := sim.log
PASS_MSG  := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- noc_arbiter.f
rtl/noc_arb_pkg.sv
rtl/route_stage.sv
rtl/rr_processor.sv
rtl/arbiter.sv
test/arbiter_checker.sv
test/arbiter_tb.sv

//--- rtl/arbiter.sv
`timescale 1ns/1ps

module arbiter #(
	parameter int COORD_W = 4
) (
	input  logic                                         clk,
	input  logic                                         rst_n_i,
	input  logic [noc_arb_pkg::addr_width(COORD_W)-1:0] router_addr_i,

	input  logic [noc_arb_pkg::addr_width(COORD_W)-1:0] addr_header_n_i,
	input  logic [noc_arb_pkg::addr_width(COORD_W)-1:0] addr_header_s_i,
	input  logic [noc_arb_pkg::addr_width(COORD_W)-1:0] addr_header_w_i,
	input  logic [noc_arb_pkg::addr_width(COORD_W)-1:0] addr_header_e_i,
	input  logic [noc_arb_pkg::addr_width(COORD_W)-1:0] addr_header_l_i,

	input  logic                                         write_n_i,
	input  logic                                         write_s_i,
	input  logic                                         write_w_i,
	input  logic                                         write_e_i,
	input  logic                                         write_l_i,

	input  logic                                         release_n_i,
	input  logic                                         release_s_i,
	input  logic                                         release_w_i,
	input  logic                                         release_e_i,
	input  logic                                         release_l_i,

	input  logic                                         change_order_n_i,
	input  logic                                         change_order_s_i,
	input  logic                                         change_order_w_i,
	input  logic                                         change_order_e_i,
	input  logic                                         change_order_l_i,

	output logic [noc_arb_pkg::NUM_PORTS-1:0]            grant_n_o,
	output logic [noc_arb_pkg::NUM_PORTS-1:0]            grant_s_o,
	output logic [noc_arb_pkg::NUM_PORTS-1:0]            grant_w_o,
	output logic [noc_arb_pkg::NUM_PORTS-1:0]            grant_e_o,
	output logic [noc_arb_pkg::NUM_PORTS-1:0]            grant_l_o,

	output logic                                         to_cs_n_o,
	output logic                                         to_cs_s_o,
	output logic                                         to_cs_w_o,
	output logic                                         to_cs_e_o,
	output logic                                         to_cs_l_o
);
	import noc_arb_pkg::*;

	// registered direction and request flag of each input
	port_e hop_n;
	port_e hop_s;
	port_e hop_w;
	port_e hop_e;
	port_e hop_l;
	logic  vld_n;
	logic  vld_s;
	logic  vld_w;
	logic  vld_e;
	logic  vld_l;

	route_stage #(.COORD_W(COORD_W)) route_n (
		.clk(clk), .rst_n_i(rst_n_i), .router_addr_i(router_addr_i),
		.addr_header_i(addr_header_n_i), .write_i(write_n_i), .release_i(release_n_i),
		.nexthop_o(hop_n), .valid_o(vld_n)
	);

	route_stage #(.COORD_W(COORD_W)) route_s (
		.clk(clk), .rst_n_i(rst_n_i), .router_addr_i(router_addr_i),
		.addr_header_i(addr_header_s_i), .write_i(write_s_i), .release_i(release_s_i),
		.nexthop_o(hop_s), .valid_o(vld_s)
	);

	route_stage #(.COORD_W(COORD_W)) route_w (
		.clk(clk), .rst_n_i(rst_n_i), .router_addr_i(router_addr_i),
		.addr_header_i(addr_header_w_i), .write_i(write_w_i), .release_i(release_w_i),
		.nexthop_o(hop_w), .valid_o(vld_w)
	);

	route_stage #(.COORD_W(COORD_W)) route_e (
		.clk(clk), .rst_n_i(rst_n_i), .router_addr_i(router_addr_i),
		.addr_header_i(addr_header_e_i), .write_i(write_e_i), .release_i(release_e_i),
		.nexthop_o(hop_e), .valid_o(vld_e)
	);

	// only this input may resolve to its own port, and that request is never granted
	route_stage #(.COORD_W(COORD_W)) route_l (
		.clk(clk), .rst_n_i(rst_n_i), .router_addr_i(router_addr_i),
		.addr_header_i(addr_header_l_i), .write_i(write_l_i), .release_i(release_l_i),
		.nexthop_o(hop_l), .valid_o(vld_l)
	);

	rr_processor #(.MY_PORT(PORT_N)) rr_n (
		.clk(clk), .rst_n_i(rst_n_i),
		.nexthop_n_i(hop_n), .nexthop_s_i(hop_s), .nexthop_w_i(hop_w),
		.nexthop_e_i(hop_e), .nexthop_l_i(hop_l),
		.valid_n_i(vld_n), .valid_s_i(vld_s), .valid_w_i(vld_w),
		.valid_e_i(vld_e), .valid_l_i(vld_l),
		.change_order_i(change_order_n_i), .grant_o(grant_n_o), .to_cs_o(to_cs_n_o)
	);

	rr_processor #(.MY_PORT(PORT_S)) rr_s (
		.clk(clk), .rst_n_i(rst_n_i),
		.nexthop_n_i(hop_n), .nexthop_s_i(hop_s), .nexthop_w_i(hop_w),
		.nexthop_e_i(hop_e), .nexthop_l_i(hop_l),
		.valid_n_i(vld_n), .valid_s_i(vld_s), .valid_w_i(vld_w),
		.valid_e_i(vld_e), .valid_l_i(vld_l),
		.change_order_i(change_order_s_i), .grant_o(grant_s_o), .to_cs_o(to_cs_s_o)
	);

	rr_processor #(.MY_PORT(PORT_W)) rr_w (
		.clk(clk), .rst_n_i(rst_n_i),
		.nexthop_n_i(hop_n), .nexthop_s_i(hop_s), .nexthop_w_i(hop_w),
		.nexthop_e_i(hop_e), .nexthop_l_i(hop_l),
		.valid_n_i(vld_n), .valid_s_i(vld_s), .valid_w_i(vld_w),
		.valid_e_i(vld_e), .valid_l_i(vld_l),
		.change_order_i(change_order_w_i), .grant_o(grant_w_o), .to_cs_o(to_cs_w_o)
	);

	rr_processor #(.MY_PORT(PORT_E)) rr_e (
		.clk(clk), .rst_n_i(rst_n_i),
		.nexthop_n_i(hop_n), .nexthop_s_i(hop_s), .nexthop_w_i(hop_w),
		.nexthop_e_i(hop_e), .nexthop_l_i(hop_l),
		.valid_n_i(vld_n), .valid_s_i(vld_s), .valid_w_i(vld_w),
		.valid_e_i(vld_e), .valid_l_i(vld_l),
		.change_order_i(change_order_e_i), .grant_o(grant_e_o), .to_cs_o(to_cs_e_o)
	);

	rr_processor #(.MY_PORT(PORT_L)) rr_l (
		.clk(clk), .rst_n_i(rst_n_i),
		.nexthop_n_i(hop_n), .nexthop_s_i(hop_s), .nexthop_w_i(hop_w),
		.nexthop_e_i(hop_e), .nexthop_l_i(hop_l),
		.valid_n_i(vld_n), .valid_s_i(vld_s), .valid_w_i(vld_w),
		.valid_e_i(vld_e), .valid_l_i(vld_l),
		.change_order_i(change_order_l_i), .grant_o(grant_l_o), .to_cs_o(to_cs_l_o)
	);

endmodule

//--- rtl/noc_arb_pkg.sv
package noc_arb_pkg;

	// each mesh direction and the local core has a port and a bit in every grant vector
	localparam int NUM_PORTS = 5;

	// bits needed to encode one direction
	localparam int PORT_IDX_W = 3;

	// the encoding doubles as the bit position of that input in a grant vector
	typedef enum logic [PORT_IDX_W-1:0] {
		PORT_N = 3'd0,
		PORT_S = 3'd1,
		PORT_W = 3'd2,
		PORT_E = 3'd3,
		PORT_L = 3'd4
	} port_e;

	// an address carries y in the upper half and x in the lower half
	function automatic int addr_width(input int coord_w);
		return 2 * coord_w;
	endfunction

	// cyclic successor in the order n, s, w, e, l
	function automatic port_e next_port(input port_e p);
		port_e n;
		if (p == PORT_L) begin
			n = PORT_N;
		end else begin
			n = port_e'(int'(p) + 1);
		end
		return n;
	endfunction

endpackage

//--- rtl/route_stage.sv
`timescale 1ns/1ps

module route_stage #(
	parameter int COORD_W = 4
) (
	input  logic                                         clk,
	input  logic                                         rst_n_i,
	input  logic [noc_arb_pkg::addr_width(COORD_W)-1:0] router_addr_i,
	input  logic [noc_arb_pkg::addr_width(COORD_W)-1:0] addr_header_i,
	input  logic                                         write_i,
	input  logic                                         release_i,
	output noc_arb_pkg::port_e                           nexthop_o,
	output logic                                         valid_o
);
	import noc_arb_pkg::*;

	logic [COORD_W-1:0] hdr_y;
	logic [COORD_W-1:0] hdr_x;
	logic [COORD_W-1:0] rtr_y;
	logic [COORD_W-1:0] rtr_x;
	port_e              route_d;
	port_e              nexthop_q;
	logic               valid_q;

	assign hdr_y = addr_header_i[2*COORD_W-1:COORD_W];
	assign hdr_x = addr_header_i[COORD_W-1:0];
	assign rtr_y = router_addr_i[2*COORD_W-1:COORD_W];
	assign rtr_x = router_addr_i[COORD_W-1:0];

	// YX order resolves the y offset first, x only once the row matches
	always_comb begin
		if (hdr_y > rtr_y) begin
			route_d = PORT_N;
		end else if (hdr_y < rtr_y) begin
			route_d = PORT_S;
		end else if (hdr_x > rtr_x) begin
			route_d = PORT_E;
		end else if (hdr_x < rtr_x) begin
			route_d = PORT_W;
		end else begin
			route_d = PORT_L;
		end
	end

	// the direction is only looked at while valid is set
	always_ff @(posedge clk) begin
		if (write_i) begin
			nexthop_q <= route_d;
		end
	end

	// a new header in the same cycle as a release keeps the input requesting
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			valid_q <= 1'b0;
		end else if (write_i) begin
			valid_q <= 1'b1;
		end else if (release_i) begin
			valid_q <= 1'b0;
		end
	end

	assign nexthop_o = nexthop_q;
	assign valid_o   = valid_q;

endmodule

//--- rtl/rr_processor.sv
`timescale 1ns/1ps

module rr_processor #(
	parameter noc_arb_pkg::port_e MY_PORT = noc_arb_pkg::PORT_N
) (
	input  logic                                 clk,
	input  logic                                 rst_n_i,
	input  noc_arb_pkg::port_e                   nexthop_n_i,
	input  noc_arb_pkg::port_e                   nexthop_s_i,
	input  noc_arb_pkg::port_e                   nexthop_w_i,
	input  noc_arb_pkg::port_e                   nexthop_e_i,
	input  noc_arb_pkg::port_e                   nexthop_l_i,
	input  logic                                 valid_n_i,
	input  logic                                 valid_s_i,
	input  logic                                 valid_w_i,
	input  logic                                 valid_e_i,
	input  logic                                 valid_l_i,
	input  logic                                 change_order_i,
	output logic [noc_arb_pkg::NUM_PORTS-1:0]    grant_o,
	output logic                                 to_cs_o
);
	import noc_arb_pkg::*;

	port_e                hop [NUM_PORTS];
	logic [NUM_PORTS-1:0] valid;
	logic [NUM_PORTS-1:0] req;
	port_e                ptr_q;
	port_e                grant_idx;
	logic                 grant_found;

	// successor in cyclic order that never lands on the port this instance serves
	function automatic port_e skip_own(input port_e p);
		port_e n;
		n = next_port(p);
		if (n == MY_PORT) begin
			n = next_port(n);
		end
		return n;
	endfunction

	assign hop[PORT_N] = nexthop_n_i;
	assign hop[PORT_S] = nexthop_s_i;
	assign hop[PORT_W] = nexthop_w_i;
	assign hop[PORT_E] = nexthop_e_i;
	assign hop[PORT_L] = nexthop_l_i;

	assign valid = {valid_l_i, valid_e_i, valid_w_i, valid_s_i, valid_n_i};

	// an input never competes for its own output
	always_comb begin
		for (int i = 0; i < NUM_PORTS; i++) begin
			req[i] = valid[i] && (hop[i] == MY_PORT) && (i != int'(MY_PORT));
		end
	end

	// walk once around the ring starting at the pointer and take the first request
	always_comb begin
		port_e idx;
		idx         = ptr_q;
		grant_idx   = ptr_q;
		grant_found = 1'b0;
		for (int k = 0; k < NUM_PORTS; k++) begin
			if (!grant_found && req[idx]) begin
				grant_found = 1'b1;
				grant_idx   = idx;
			end
			idx = next_port(idx);
		end
	end

	always_comb begin
		grant_o = '0;
		if (grant_found) begin
			grant_o[grant_idx] = 1'b1;
		end
	end

	assign to_cs_o = grant_found;

	// the grantee drops to lowest priority once the switch is done with it
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			ptr_q <= skip_own(MY_PORT);
		end else if (change_order_i && grant_found) begin
			ptr_q <= skip_own(grant_idx);
		end
	end

endmodule

//--- test/arbiter_cases.txt
# op port header grant_n grant_s grant_w grant_e grant_l
# write and release name an input, order names an output, header is hex with y high and x low
# grants are binary with bit 0 for north up to bit 4 for local, router sits at 22
check   0 00 00000 00000 00000 00000 00000
# yx routing from each input
write   0 12 00000 00000 00000 00000 00000
check   0 00 00000 00001 00000 00000 00000
release 0 00 00000 00000 00000 00000 00000
write   1 32 00000 00000 00000 00000 00000
check   0 00 00010 00000 00000 00000 00000
release 1 00 00000 00000 00000 00000 00000
write   2 24 00000 00000 00000 00000 00000
check   0 00 00000 00000 00000 00100 00000
release 2 00 00000 00000 00000 00000 00000
write   3 20 00000 00000 00000 00000 00000
check   0 00 00000 00000 01000 00000 00000
release 3 00 00000 00000 00000 00000 00000
write   4 22 00000 00000 00000 00000 00000
check   0 00 00000 00000 00000 00000 00000
write   4 52 00000 00000 00000 00000 00000
check   0 00 10000 00000 00000 00000 00000
release 4 00 00000 00000 00000 00000 00000
# three inputs contend for east
write   0 25 00000 00000 00000 00000 00000
write   1 25 00000 00000 00000 00000 00000
write   2 25 00000 00000 00000 00000 00000
check   0 00 00000 00000 00000 00001 00000
order   3 00 00000 00000 00000 00000 00000
check   0 00 00000 00000 00000 00010 00000
order   3 00 00000 00000 00000 00000 00000
check   0 00 00000 00000 00000 00100 00000
order   3 00 00000 00000 00000 00000 00000
check   0 00 00000 00000 00000 00001 00000
release 0 00 00000 00000 00000 00000 00000
check   0 00 00000 00000 00000 00010 00000
release 1 00 00000 00000 00000 00000 00000
check   0 00 00000 00000 00000 00100 00000
release 2 00 00000 00000 00000 00000 00000
check   0 00 00000 00000 00000 00000 00000
# order on an idle output, then four inputs contend for south
order   1 00 00000 00000 00000 00000 00000
write   3 12 00000 00000 00000 00000 00000
write   4 12 00000 00000 00000 00000 00000
write   0 12 00000 00000 00000 00000 00000
write   2 12 00000 00000 00000 00000 00000
check   0 00 00000 00100 00000 00000 00000
order   1 00 00000 00000 00000 00000 00000
check   0 00 00000 01000 00000 00000 00000
order   1 00 00000 00000 00000 00000 00000
check   0 00 00000 10000 00000 00000 00000
order   1 00 00000 00000 00000 00000 00000
check   0 00 00000 00001 00000 00000 00000
# new headers spread the inputs over all outputs
write   2 24 00000 00000 00000 00000 00000
write   4 52 00000 00000 00000 00000 00000
write   1 20 00000 00000 00000 00000 00000
write   0 22 00000 00000 00000 00000 00000
check   0 00 10000 01000 00010 00100 00001
release 0 00 00000 00000 00000 00000 00000
release 1 00 00000 00000 00000 00000 00000
release 2 00 00000 00000 00000 00000 00000
release 3 00 00000 00000 00000 00000 00000
release 4 00 00000 00000 00000 00000 00000
check   0 00 00000 00000 00000 00000 00000

//--- test/arbiter_checker.sv
`timescale 1ns/1ps

module arbiter_checker (
	input logic                              clk,
	input logic                              rst_n_i,
	input logic [noc_arb_pkg::NUM_PORTS-1:0] grant_n_i,
	input logic [noc_arb_pkg::NUM_PORTS-1:0] grant_s_i,
	input logic [noc_arb_pkg::NUM_PORTS-1:0] grant_w_i,
	input logic [noc_arb_pkg::NUM_PORTS-1:0] grant_e_i,
	input logic [noc_arb_pkg::NUM_PORTS-1:0] grant_l_i,
	input logic                              to_cs_n_i,
	input logic                              to_cs_s_i,
	input logic                              to_cs_w_i,
	input logic                              to_cs_e_i,
	input logic                              to_cs_l_i
);
	import noc_arb_pkg::*;

	logic [NUM_PORTS-1:0] grant [NUM_PORTS];
	logic [NUM_PORTS-1:0] to_cs;
	int                   fail_count = 0;

	assign grant[PORT_N] = grant_n_i;
	assign grant[PORT_S] = grant_s_i;
	assign grant[PORT_W] = grant_w_i;
	assign grant[PORT_E] = grant_e_i;
	assign grant[PORT_L] = grant_l_i;

	assign to_cs = {to_cs_l_i, to_cs_e_i, to_cs_w_i, to_cs_s_i, to_cs_n_i};

	for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
		grant_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
			$onehot0(grant[p]))
			else begin
				fail_count++;
				$error("output %0d grants more than one input", p);
			end

		// an input never competes for its own output
		grant_not_self: assert property (@(posedge clk) disable iff (!rst_n_i)
			!grant[p][p])
			else begin
				fail_count++;
				$error("output %0d grants its own input", p);
			end

		switch_enable: assert property (@(posedge clk) disable iff (!rst_n_i)
			to_cs[p] == (|grant[p]))
			else begin
				fail_count++;
				$error("to_cs of output %0d does not follow its grant vector", p);
			end

		// the valid flags need one reset edge before the grants are known to be clear
		grant_in_reset: assert property (@(posedge clk)
			(!rst_n_i && $past(!rst_n_i)) |-> grant[p] == '0)
			else begin
				fail_count++;
				$error("output %0d grants while reset is held", p);
			end
	end

endmodule

bind arbiter arbiter_checker arbiter_checker_inst (
	.clk(clk), .rst_n_i(rst_n_i),
	.grant_n_i(grant_n_o), .grant_s_i(grant_s_o), .grant_w_i(grant_w_o),
	.grant_e_i(grant_e_o), .grant_l_i(grant_l_o),
	.to_cs_n_i(to_cs_n_o), .to_cs_s_i(to_cs_s_o), .to_cs_w_i(to_cs_w_o),
	.to_cs_e_i(to_cs_e_o), .to_cs_l_i(to_cs_l_o)
);

//--- test/arbiter_tb.sv
`timescale 1ns/1ps

module arbiter_tb;
	import noc_arb_pkg::*;

	localparam int    COORD_W         = 4;
	localparam int    ADDR_W          = 2 * COORD_W;
	localparam int    CLK_PERIOD      = 8;
	localparam int    RESET_CYCLES    = 10;
	localparam int    CYCLES_PER_CASE = 20;
	localparam int    MAX_CASES       = 128;
	localparam int    SEED            = 26;
	localparam string CASE_FILE       = "test/arbiter_cases.txt";

	typedef enum logic [1:0] {
		OP_WRITE,
		OP_RELEASE,
		OP_ORDER,
		OP_CHECK
	} op_e;

	logic                 clk;
	logic                 rst_n_i;
	logic [ADDR_W-1:0]    router_addr;
	logic [ADDR_W-1:0]    addr_header [NUM_PORTS];
	logic [NUM_PORTS-1:0] write_v;
	logic [NUM_PORTS-1:0] release_v;
	logic [NUM_PORTS-1:0] order_v;
	logic [NUM_PORTS-1:0] grant [NUM_PORTS];
	logic [NUM_PORTS-1:0] to_cs;

	op_e                  case_op   [MAX_CASES];
	int                   case_port [MAX_CASES];
	logic [ADDR_W-1:0]    case_hdr  [MAX_CASES];
	logic [NUM_PORTS-1:0] case_exp  [MAX_CASES][NUM_PORTS];
	int                   num_cases;
	bit                   cases_loaded;
	int                   check_count;
	int                   error_count;

	arbiter #(.COORD_W(COORD_W)) arbiter_inst (
		.clk(clk), .rst_n_i(rst_n_i), .router_addr_i(router_addr),
		.addr_header_n_i(addr_header[0]), .addr_header_s_i(addr_header[1]),
		.addr_header_w_i(addr_header[2]), .addr_header_e_i(addr_header[3]),
		.addr_header_l_i(addr_header[4]),
		.write_n_i(write_v[0]), .write_s_i(write_v[1]), .write_w_i(write_v[2]),
		.write_e_i(write_v[3]), .write_l_i(write_v[4]),
		.release_n_i(release_v[0]), .release_s_i(release_v[1]), .release_w_i(release_v[2]),
		.release_e_i(release_v[3]), .release_l_i(release_v[4]),
		.change_order_n_i(order_v[0]), .change_order_s_i(order_v[1]),
		.change_order_w_i(order_v[2]), .change_order_e_i(order_v[3]),
		.change_order_l_i(order_v[4]),
		.grant_n_o(grant[0]), .grant_s_o(grant[1]), .grant_w_o(grant[2]),
		.grant_e_o(grant[3]), .grant_l_o(grant[4]),
		.to_cs_n_o(to_cs[0]), .to_cs_s_o(to_cs[1]), .to_cs_w_o(to_cs[2]),
		.to_cs_e_o(to_cs[3]), .to_cs_l_o(to_cs[4])
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic string dir_name(input int p);
		string name;
		case (p)
			0: name = "n";
			1: name = "s";
			2: name = "w";
			3: name = "e";
			default: name = "l";
		endcase
		return name;
	endfunction

	task automatic check_value(input string name, input logic [NUM_PORTS-1:0] expected,
			input logic [NUM_PORTS-1:0] actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("[ERROR] %0t %s expected %b got %b", $time, name, expected, actual);
		end
	endtask

	task automatic load_cases();
		int                   fd;
		int                   sp;
		int                   fields;
		int                   port;
		string                line;
		string                op_txt;
		logic [ADDR_W-1:0]    hdr;
		logic [NUM_PORTS-1:0] exp_g [NUM_PORTS];
		fd = $fopen(CASE_FILE, "r");
		if (fd == 0) begin
			$display("cannot open %s so no case was run", CASE_FILE);
			error_count++;
			return;
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line.getc(0) == "#") begin
				continue;
			end
			// the opcode is the text before the first space
			sp = 0;
			while (sp < line.len() && line.getc(sp) != " ") begin
				sp++;
			end
			op_txt = line.substr(0, sp - 1);
			fields = $sscanf(line.substr(sp, line.len() - 1), "%d %h %b %b %b %b %b",
				port, hdr, exp_g[0], exp_g[1], exp_g[2], exp_g[3], exp_g[4]);
			if (fields != 7 || port < 0 || port >= NUM_PORTS || num_cases == MAX_CASES) begin
				$display("skipped a case line that is malformed or beyond the limit: %s", line);
				error_count++;
				continue;
			end
			if (op_txt == "write") begin
				case_op[num_cases] = OP_WRITE;
			end else if (op_txt == "release") begin
				case_op[num_cases] = OP_RELEASE;
			end else if (op_txt == "order") begin
				case_op[num_cases] = OP_ORDER;
			end else if (op_txt == "check") begin
				case_op[num_cases] = OP_CHECK;
			end else begin
				$display("unknown opcode %s in the case file", op_txt);
				error_count++;
				continue;
			end
			case_port[num_cases] = port;
			case_hdr[num_cases]  = hdr;
			for (int p = 0; p < NUM_PORTS; p++) begin
				case_exp[num_cases][p] = exp_g[p];
			end
			num_cases++;
		end
		$fclose(fd);
	endtask

	// drives a one cycle pulse that the DUT sees on the edge after it is driven
	task automatic drive_op(input op_e op, input int port, input logic [ADDR_W-1:0] hdr);
		@(posedge clk);
		if (op == OP_WRITE) begin
			addr_header[port] <= hdr;
			write_v[port]     <= 1'b1;
		end else if (op == OP_RELEASE) begin
			release_v[port] <= 1'b1;
		end else begin
			order_v[port] <= 1'b1;
		end
		@(posedge clk);
		write_v   <= '0;
		release_v <= '0;
		order_v   <= '0;
	endtask

	task automatic check_grants(input int idx);
		logic exp_cs;
		@(negedge clk);
		for (int p = 0; p < NUM_PORTS; p++) begin
			// the switch is enabled exactly when the output grants someone
			exp_cs = |case_exp[idx][p];
			check_value({"grant_", dir_name(p), "_o"}, case_exp[idx][p], grant[p]);
			check_value({"to_cs_", dir_name(p), "_o"}, NUM_PORTS'(exp_cs),
				NUM_PORTS'(to_cs[p]));
		end
	endtask

	// a check looks in the cycle right after the edge that took the previous operation
	task automatic run_case(input int idx);
		int gap;
		if (case_op[idx] == OP_CHECK) begin
			check_grants(idx);
		end else begin
			gap = $urandom_range(0, 3);
			repeat (gap) @(posedge clk);
			drive_op(case_op[idx], case_port[idx], case_hdr[idx]);
		end
	endtask

	initial begin : main
		int assert_fails;
		void'($urandom(SEED));
		rst_n_i     <= 1'b0;
		router_addr <= 8'h22;
		write_v     <= '0;
		release_v   <= '0;
		order_v     <= '0;
		for (int p = 0; p < NUM_PORTS; p++) begin
			addr_header[p] <= '0;
		end
		load_cases();
		cases_loaded = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n_i <= 1'b1;
		for (int i = 0; i < num_cases; i++) begin
			run_case(i);
		end
		repeat (2) @(posedge clk);
		assert_fails = arbiter_inst.arbiter_checker_inst.fail_count;
		$display("checks %0d, mismatches %0d, assertion failures %0d",
			check_count, error_count, assert_fails);
		if (error_count == 0 && assert_fails == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	initial begin : watchdog
		int limit;
		wait (cases_loaded);
		limit = (num_cases + 1) * CYCLES_PER_CASE + RESET_CYCLES;
		#(limit * CLK_PERIOD);
		$display("timeout after %0d clock cycles with the case sequence unfinished", limit);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule
